// File: source/pixel_priority_pkg.sv
`default_nettype none

package pixel_priority_pkg;

    localparam int MAX_BG  = 4;  // ceiling for NUM_BG
    localparam int PRAM_AW = 7;  // 128 words, two entries each
    localparam int COLOR_W = 15;

    // display control bits
    localparam int DISP_BG_EN_LSB = 8;
    localparam int DISP_OBJ_EN    = 12;
    localparam int DISP_WIN0_EN   = 13;
    localparam int DISP_WIN1_EN   = 14;
    localparam int DISP_OBJWIN_EN = 15;

    // window control byte, same layout for win0, win1, outside and obj window
    localparam int WIN_BG_EN_LSB = 0;
    localparam int WIN_OBJ_EN    = 4;
    localparam int EFFECTS_BIT   = 5;

    localparam logic [1:0] OBJ_MODE_NORMAL = 2'd0;
    localparam logic [1:0] OBJ_MODE_SEMI   = 2'd1;
    localparam logic [1:0] OBJ_MODE_WINDOW = 2'd2;  // marks obj window only

    typedef struct packed {
        logic [5:0] rsvd;
        logic [3:0] bank;
        logic [1:0] prio;   // lower wins
        logic [7:0] index;  // 0 is transparent
    } bg_view_t;

    typedef struct packed {
        logic [7:0] rsvd;
        logic [1:0] mode;
        logic [1:0] prio;
        logic [7:0] index;
    } obj_view_t;

    // index and prio sit at the same bits in both views
    typedef union packed {
        bg_view_t  bg;
        obj_view_t obj;
    } layer_word_u;

    typedef enum logic [2:0] {
        LAYER_BG0      = 3'd0,
        LAYER_BG1      = 3'd1,
        LAYER_BG2      = 3'd2,
        LAYER_BG3      = 3'd3,
        LAYER_OBJ      = 3'd4,
        LAYER_BACKDROP = 3'd5
    } layer_id_e;

    localparam layer_word_u BACKDROP_WORD = '0;  // palette entry 0

endpackage

`default_nettype wire

// File: source/window_mask.sv
`timescale 1ns/1ps
`default_nettype none

module window_mask #(
    parameter int NUM_BG = 4
) (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         pixel_valid,
    input  logic [7:0]                                   col,
    input  logic [7:0]                                   line,
    input  pixel_priority_pkg::layer_word_u              obj_word,
    input  pixel_priority_pkg::layer_word_u [NUM_BG-1:0] bg_words,
    input  logic [15:0]                                  disp_ctrl,
    input  logic [15:0]                                  win_in,
    input  logic [15:0]                                  win_out,
    input  logic [15:0]                                  win0_h,
    input  logic [15:0]                                  win1_h,
    input  logic [15:0]                                  win0_v,
    input  logic [15:0]                                  win1_v,
    output logic                                         mask_valid,
    output logic [NUM_BG:0]                              layer_en,
    output logic                                         effects_en,
    output pixel_priority_pkg::layer_word_u              obj_word_q,
    output pixel_priority_pkg::layer_word_u [NUM_BG-1:0] bg_words_q
);
    import pixel_priority_pkg::*;

    logic                 in_win0;
    logic                 in_win1;
    logic                 on_obj_win;
    logic                 any_win;
    logic [EFFECTS_BIT:0] ctrl_sel;
    logic [MAX_BG-1:0]    bg_en_all;
    logic [NUM_BG:0]      layer_en_d;

    // start inclusive, end exclusive
    function automatic logic in_span(input logic [7:0] pos, input logic [15:0] span);
        return (pos >= span[15:8]) && (pos < span[7:0]);
    endfunction

    assign in_win0 = disp_ctrl[DISP_WIN0_EN] && in_span(col, win0_h) && in_span(line, win0_v);
    assign in_win1 = disp_ctrl[DISP_WIN1_EN] && in_span(col, win1_h) && in_span(line, win1_v);

    assign on_obj_win = disp_ctrl[DISP_OBJWIN_EN]
                     && (obj_word.obj.mode == OBJ_MODE_WINDOW)
                     && (obj_word.obj.index != 8'd0);

    assign any_win = disp_ctrl[DISP_WIN0_EN] | disp_ctrl[DISP_WIN1_EN]
                   | disp_ctrl[DISP_OBJWIN_EN];

    always_comb begin
        if (!any_win) begin
            ctrl_sel = '1;  // no windows, everything on
        end else if (in_win0) begin
            ctrl_sel = win_in[EFFECTS_BIT:0];
        end else if (in_win1) begin
            ctrl_sel = win_in[8 +: EFFECTS_BIT + 1];
        end else if (on_obj_win) begin
            ctrl_sel = win_out[8 +: EFFECTS_BIT + 1];
        end else begin
            ctrl_sel = win_out[EFFECTS_BIT:0];  // outside
        end
    end

    assign bg_en_all  = ctrl_sel[WIN_BG_EN_LSB +: MAX_BG] & disp_ctrl[DISP_BG_EN_LSB +: MAX_BG];
    assign layer_en_d = {bg_en_all[NUM_BG-1:0], ctrl_sel[WIN_OBJ_EN] & disp_ctrl[DISP_OBJ_EN]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mask_valid <= 1'b0;
            layer_en   <= '0;
            effects_en <= 1'b0;
        end else begin
            mask_valid <= pixel_valid;
            if (pixel_valid) begin
                layer_en   <= layer_en_d;
                effects_en <= ctrl_sel[EFFECTS_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            obj_word_q <= obj_word;
            bg_words_q <= bg_words;
        end
    end

endmodule

`default_nettype wire

// File: source/rank_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rank_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_valid,
    input  logic                           in_effects,
    input  pixel_priority_pkg::layer_word_u cand_word,
    input  pixel_priority_pkg::layer_id_e   cand_id,
    input  logic                           cand_en,
    input  pixel_priority_pkg::layer_word_u top_word_in,
    input  pixel_priority_pkg::layer_id_e   top_id_in,
    input  pixel_priority_pkg::layer_word_u bot_word_in,
    input  pixel_priority_pkg::layer_id_e   bot_id_in,
    output logic                           out_valid,
    output logic                           out_effects,
    output pixel_priority_pkg::layer_word_u top_word_out,
    output pixel_priority_pkg::layer_id_e   top_id_out,
    output pixel_priority_pkg::layer_word_u bot_word_out,
    output pixel_priority_pkg::layer_id_e   bot_id_out
);
    import pixel_priority_pkg::*;

    logic obj_win_word;
    logic is_cand;
    logic beats_top;
    logic beats_bot;

    // strict compare, so ties stay with the earlier slot
    function automatic logic outranks(input layer_word_u cand,
                                      input layer_word_u held,
                                      input layer_id_e   held_id);
        return (held_id == LAYER_BACKDROP) || (cand.bg.prio < held.bg.prio);
    endfunction

    assign obj_win_word = (cand_id == LAYER_OBJ) && (cand_word.obj.mode == OBJ_MODE_WINDOW);
    assign is_cand      = cand_en && (cand_word.bg.index != 8'd0) && !obj_win_word;

    assign beats_top = is_cand && outranks(cand_word, top_word_in, top_id_in);
    assign beats_bot = is_cand && outranks(cand_word, bot_word_in, bot_id_in);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_effects <= in_effects;
            if (beats_top) begin
                top_word_out <= cand_word;
                top_id_out   <= cand_id;
                bot_word_out <= top_word_in;  // old top drops to second
                bot_id_out   <= top_id_in;
            end else if (beats_bot) begin
                top_word_out <= top_word_in;
                top_id_out   <= top_id_in;
                bot_word_out <= cand_word;
                bot_id_out   <= cand_id;
            end else begin
                top_word_out <= top_word_in;
                top_id_out   <= top_id_in;
                bot_word_out <= bot_word_in;
                bot_id_out   <= bot_id_in;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/palette_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module palette_fetch #(
    parameter int NUM_BG = 4
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     rank_valid,
    input  logic                                     rank_effects,
    input  pixel_priority_pkg::layer_word_u           top_word,
    input  pixel_priority_pkg::layer_id_e             top_id,
    input  pixel_priority_pkg::layer_word_u           bot_word,
    input  pixel_priority_pkg::layer_id_e             bot_id,
    input  logic [31:0]                              pram_data,
    output logic                                     pram_read,
    output logic [pixel_priority_pkg::PRAM_AW-1:0]   pram_addr,
    output logic                                     color_valid,
    output logic [pixel_priority_pkg::COLOR_W-1:0]   color_top,
    output logic [pixel_priority_pkg::COLOR_W-1:0]   color_bottom,
    output pixel_priority_pkg::layer_id_e             layer_top,
    output pixel_priority_pkg::layer_id_e             layer_bottom,
    output logic                                     effects_en
);
    import pixel_priority_pkg::*;

    logic               fetch_top_q;  // top data on the bus and bottom read out
    logic               fetch_bot_q;  // bottom data on the bus
    logic               shared_word;
    logic [7:0]         top_idx_q;
    logic [7:0]         bot_idx_q;
    layer_id_e          top_id_q;
    layer_id_e          bot_id_q;
    logic               effects_q;
    logic [31:0]        word_hold_q;
    logic [31:0]        bot_src;
    logic [COLOR_W-1:0] top_color_q;
    logic [COLOR_W-1:0] bot_color;

    // odd entries live in the upper half
    function automatic logic [COLOR_W-1:0] pick_half(input logic [31:0] word, input logic odd);
        return odd ? word[30:16] : word[14:0];
    endfunction

    assign shared_word = (top_idx_q[7:1] == bot_idx_q[7:1]);

    // second read skipped when both entries sit in one word
    assign pram_read = rank_valid | (fetch_top_q & ~shared_word);
    assign pram_addr = fetch_top_q ? bot_idx_q[7:1] : top_word.bg.index[7:1];

    assign bot_src   = shared_word ? word_hold_q : pram_data;
    assign bot_color = pick_half(bot_src, bot_idx_q[0]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_top_q <= 1'b0;
            fetch_bot_q <= 1'b0;
            color_valid <= 1'b0;
        end else begin
            fetch_top_q <= rank_valid;
            fetch_bot_q <= fetch_top_q;
            color_valid <= fetch_bot_q;
        end
    end

    // pixel context held until the outputs load
    always_ff @(posedge clk) begin
        if (rank_valid) begin
            top_idx_q <= top_word.bg.index;
            bot_idx_q <= bot_word.bg.index;
            top_id_q  <= top_id;
            bot_id_q  <= bot_id;
            effects_q <= rank_effects;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_top_q) begin
            top_color_q <= pick_half(pram_data, top_idx_q[0]);
            word_hold_q <= pram_data;  // reused if bottom shares the word
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_bot_q) begin
            color_top    <= top_color_q;
            color_bottom <= bot_color;
            layer_top    <= top_id_q;
            layer_bottom <= bot_id_q;
            effects_en   <= effects_q;
        end
    end

endmodule

`default_nettype wire

// File: source/pixel_priority_top.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_priority_top #(
    parameter int NUM_BG = 4
) (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         pixel_valid,
    input  logic [7:0]                                   col,
    input  logic [7:0]                                   line,
    input  pixel_priority_pkg::layer_word_u              obj_word,
    input  pixel_priority_pkg::layer_word_u [NUM_BG-1:0] bg_words,
    input  logic [15:0]                                  disp_ctrl,
    input  logic [15:0]                                  win_in,
    input  logic [15:0]                                  win_out,
    input  logic [15:0]                                  win0_h,
    input  logic [15:0]                                  win1_h,
    input  logic [15:0]                                  win0_v,
    input  logic [15:0]                                  win1_v,
    input  logic [31:0]                                  pram_data,
    output logic                                         pram_read,
    output logic [pixel_priority_pkg::PRAM_AW-1:0]       pram_addr,
    output logic                                         color_valid,
    output logic [pixel_priority_pkg::COLOR_W-1:0]       color_top,
    output logic [pixel_priority_pkg::COLOR_W-1:0]       color_bottom,
    output pixel_priority_pkg::layer_id_e                 layer_top,
    output pixel_priority_pkg::layer_id_e                 layer_bottom,
    output logic                                         effects_en
);
    import pixel_priority_pkg::*;

    logic                     mask_valid;
    logic                     mask_effects;
    logic [NUM_BG:0]          layer_en;
    layer_word_u              obj_word_q;
    layer_word_u [NUM_BG-1:0] bg_words_q;

    // slot 0 is obj, slot k+1 is bg k; row g feeds stage g
    layer_word_u [NUM_BG:0]   word_row [NUM_BG+1];
    logic [NUM_BG:0]          en_row   [NUM_BG+1];

    logic                     valid_chain    [NUM_BG+2];
    logic                     effects_chain  [NUM_BG+2];
    layer_word_u              top_word_chain [NUM_BG+2];
    layer_id_e                top_id_chain   [NUM_BG+2];
    layer_word_u              bot_word_chain [NUM_BG+2];
    layer_id_e                bot_id_chain   [NUM_BG+2];

    window_mask #(
        .NUM_BG (NUM_BG)
    ) u_window_mask (
        .clk         (clk),
        .arst_n      (arst_n),
        .pixel_valid (pixel_valid),
        .col         (col),
        .line        (line),
        .obj_word    (obj_word),
        .bg_words    (bg_words),
        .disp_ctrl   (disp_ctrl),
        .win_in      (win_in),
        .win_out     (win_out),
        .win0_h      (win0_h),
        .win1_h      (win1_h),
        .win0_v      (win0_v),
        .win1_v      (win1_v),
        .mask_valid  (mask_valid),
        .layer_en    (layer_en),
        .effects_en  (mask_effects),
        .obj_word_q  (obj_word_q),
        .bg_words_q  (bg_words_q)
    );

    // chain starts from a backdrop pair
    assign valid_chain[0]    = mask_valid;
    assign effects_chain[0]  = mask_effects;
    assign top_word_chain[0] = BACKDROP_WORD;
    assign top_id_chain[0]   = LAYER_BACKDROP;
    assign bot_word_chain[0] = BACKDROP_WORD;
    assign bot_id_chain[0]   = LAYER_BACKDROP;

    for (genvar g = 0; g <= NUM_BG; g++) begin : g_stage
        localparam layer_id_e CAND_ID = (g == 0) ? LAYER_OBJ : layer_id_e'(g - 1);

        if (g == 0) begin : g_row_head
            assign word_row[0] = {bg_words_q, obj_word_q};
            assign en_row[0]   = layer_en;
        end else begin : g_row_skew
            always_ff @(posedge clk) begin
                word_row[g] <= word_row[g-1];  // one cycle of skew per stage
                en_row[g]   <= en_row[g-1];
            end
        end

        rank_stage u_rank_stage (
            .clk          (clk),
            .arst_n       (arst_n),
            .in_valid     (valid_chain[g]),
            .in_effects   (effects_chain[g]),
            .cand_word    (word_row[g][g]),
            .cand_id      (CAND_ID),
            .cand_en      (en_row[g][g]),
            .top_word_in  (top_word_chain[g]),
            .top_id_in    (top_id_chain[g]),
            .bot_word_in  (bot_word_chain[g]),
            .bot_id_in    (bot_id_chain[g]),
            .out_valid    (valid_chain[g+1]),
            .out_effects  (effects_chain[g+1]),
            .top_word_out (top_word_chain[g+1]),
            .top_id_out   (top_id_chain[g+1]),
            .bot_word_out (bot_word_chain[g+1]),
            .bot_id_out   (bot_id_chain[g+1])
        );
    end

    palette_fetch #(
        .NUM_BG (NUM_BG)
    ) u_palette_fetch (
        .clk          (clk),
        .arst_n       (arst_n),
        .rank_valid   (valid_chain[NUM_BG+1]),
        .rank_effects (effects_chain[NUM_BG+1]),
        .top_word     (top_word_chain[NUM_BG+1]),
        .top_id       (top_id_chain[NUM_BG+1]),
        .bot_word     (bot_word_chain[NUM_BG+1]),
        .bot_id       (bot_id_chain[NUM_BG+1]),
        .pram_data    (pram_data),
        .pram_read    (pram_read),
        .pram_addr    (pram_addr),
        .color_valid  (color_valid),
        .color_top    (color_top),
        .color_bottom (color_bottom),
        .layer_top    (layer_top),
        .layer_bottom (layer_bottom),
        .effects_en   (effects_en)
    );

endmodule

`default_nettype wire

// File: verification/pixel_priority_model.svh
typedef struct {
    logic [COLOR_W-1:0] top_color;
    logic [COLOR_W-1:0] bot_color;
    layer_id_e          top_id;
    layer_id_e          bot_id;
    logic               effects;
    logic               obj_win;  // obj word only marks the window
    int                 reads;
    int                 issue_cyc;
} exp_t;

// palette fill, depends on all 8 index bits
function automatic logic [COLOR_W-1:0] entry_color(input logic [7:0] e);
    return 15'({e, 7'h00} ^ (e * 15'd331) ^ 15'h2b5);
endfunction

function automatic logic inside_window(input logic [7:0] c, input logic [7:0] l,
                                       input logic [15:0] h, input logic [15:0] v);
    return (c >= h[15:8]) && (c < h[7:0]) && (l >= v[15:8]) && (l < v[7:0]);
endfunction

function automatic exp_t ref_pixel(input logic [7:0] c, input logic [7:0] l,
        input layer_word_u obj, input layer_word_u [NUM_BG-1:0] bg, input logic [15:0] dc,
        input logic [15:0] wi, input logic [15:0] wo, input logic [15:0] w0h,
        input logic [15:0] w1h, input logic [15:0] w0v, input logic [15:0] w1v);
    exp_t        e;
    logic [7:0]  ctl;
    layer_word_u slot [NUM_BG+1];
    logic        cand [NUM_BG+1];
    int          pick [2];
    logic [7:0]  idx [2];
    layer_id_e   ids [2];
    e.obj_win = (obj.obj.mode == OBJ_MODE_WINDOW);
    ctl = (dc[DISP_OBJWIN_EN:DISP_WIN0_EN] == 3'b000) ? 8'hff
        : (dc[DISP_WIN0_EN] && inside_window(c, l, w0h, w0v)) ? wi[7:0]
        : (dc[DISP_WIN1_EN] && inside_window(c, l, w1h, w1v)) ? wi[15:8]
        : (dc[DISP_OBJWIN_EN] && e.obj_win && obj.obj.index != 0) ? wo[15:8] : wo[7:0];
    slot[0] = obj;
    cand[0] = ctl[WIN_OBJ_EN] && dc[DISP_OBJ_EN] && !e.obj_win;
    for (int k = 0; k < NUM_BG; k++) begin
        slot[k+1] = bg[k];
        cand[k+1] = ctl[WIN_BG_EN_LSB + k] && dc[DISP_BG_EN_LSB + k];
    end
    // first pass finds the top, second the runner-up; strict compare keeps earlier slot
    for (int p = 0; p < 2; p++) begin
        pick[p] = -1;
        for (int s = 0; s <= NUM_BG; s++) begin
            if (cand[s] && slot[s].obj.index != 0 && (p == 0 || s != pick[0])
                && (pick[p] < 0 || slot[s].obj.prio < slot[pick[p]].obj.prio)) begin
                pick[p] = s;
            end
        end
        if (pick[p] < 0) begin
            ids[p] = LAYER_BACKDROP;
            idx[p] = 8'd0;
        end else begin
            ids[p] = (pick[p] == 0) ? LAYER_OBJ : layer_id_e'(pick[p] - 1);
            idx[p] = slot[pick[p]].obj.index;
        end
    end
    e.top_id    = ids[0];
    e.bot_id    = ids[1];
    e.top_color = entry_color(idx[0]);
    e.bot_color = entry_color(idx[1]);
    e.effects   = ctl[EFFECTS_BIT];
    e.reads     = (idx[0][7:1] == idx[1][7:1]) ? 1 : 2;  // one read if same word
    e.issue_cyc = 0;
    return e;
endfunction

task automatic record_check(input string name, input logic ok, input string got,
                            input string want);
    checks++;
    if (!ok) begin
        errors++;
        $display("mismatch at %0t: %s got %s expected %s", $time, name, got, want);
    end
endtask

task automatic check_color(input string name, input logic [COLOR_W-1:0] got, want);
    record_check(name, got === want, $sformatf("%h", got), $sformatf("%h", want));
endtask

task automatic check_layer(input string name, input layer_id_e got, want);
    record_check(name, got === want, $sformatf("%s(%0d)", got.name(), got), want.name());
endtask

task automatic check_flag(input string name, input logic got, want);
    record_check(name, got === want, $sformatf("%b", got), $sformatf("%b", want));
endtask

task automatic check_count(input string name, input int got, want);
    record_check(name, got == want, $sformatf("%0d", got), $sformatf("%0d", want));
endtask

// File: verification/pixel_priority_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_priority_tb;
    import pixel_priority_pkg::*;

    localparam int NUM_BG  = 4;
    localparam int LATENCY = NUM_BG + 5;

    typedef layer_word_u [NUM_BG-1:0] bg_set_t;

    logic               clk;
    logic               arst_n;
    logic               pixel_valid;
    logic [7:0]         col;
    logic [7:0]         line;
    layer_word_u        obj_word;
    bg_set_t            bg_words;
    logic [15:0]        disp_ctrl;
    logic [15:0]        win_in;
    logic [15:0]        win_out;
    logic [15:0]        win0_h;
    logic [15:0]        win1_h;
    logic [15:0]        win0_v;
    logic [15:0]        win1_v;
    logic [31:0]        pram_data;
    logic               pram_read;
    logic [PRAM_AW-1:0] pram_addr;
    logic               color_valid;
    logic [COLOR_W-1:0] color_top;
    logic [COLOR_W-1:0] color_bottom;
    layer_id_e          layer_top;
    layer_id_e          layer_bottom;
    logic               effects_en;

    logic [31:0]        pram [1 << PRAM_AW];
    logic               rd_pending = 1'b0;
    logic [PRAM_AW-1:0] rd_addr;
    int                 cyc = 0;
    int                 reads = 0;
    int                 pred_reads = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 err_mark = 0;

    `include "pixel_priority_model.svh"

    exp_t exp_q[$];
    exp_t head;

    pixel_priority_top #(.NUM_BG(NUM_BG)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // palette memory, data one cycle after the strobe, junk when idle
    always @(negedge clk) begin
        pram_data  = rd_pending ? pram[rd_addr] : 32'h5a5a_a5a5;
        rd_pending = (pram_read === 1'b1);
        rd_addr    = pram_addr;
        if (rd_pending) begin
            reads++;
        end
    end

    always @(negedge clk) begin
        if (color_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("color_valid at %0t with no pixel in flight", $time);
            end else begin
                head = exp_q.pop_front();
                check_color("color_top", color_top, head.top_color);
                check_color("color_bottom", color_bottom, head.bot_color);
                check_layer("layer_top", layer_top, head.top_id);
                check_layer("layer_bottom", layer_bottom, head.bot_id);
                check_flag("effects_en", effects_en, head.effects);
                check_count("latency", cyc - head.issue_cyc, LATENCY);
                if (head.obj_win) begin
                    check_flag("obj hidden", layer_top != LAYER_OBJ && layer_bottom != LAYER_OBJ,
                               1'b1);
                end
            end
        end
    end

    task automatic send_pixel(input logic [7:0] c, input logic [7:0] l, input layer_word_u o,
                              input bg_set_t b);
        exp_t e;
        @(negedge clk);
        col         = c;
        line        = l;
        obj_word    = o;
        bg_words    = b;
        pixel_valid = 1'b1;
        e = ref_pixel(c, l, o, b, disp_ctrl, win_in, win_out, win0_h, win1_h, win0_v, win1_v);
        e.issue_cyc = cyc;
        exp_q.push_back(e);
        pred_reads += e.reads;
        @(negedge clk);
        pixel_valid = 1'b0;  // next strobe two cycles on at the earliest
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout at %0t with %0d results never seen", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    function automatic layer_word_u make_word(input logic [7:0] index, input logic [1:0] prio,
                                              input logic [1:0] mode);
        layer_word_u w;
        w           = '0;
        w.obj.index = index;
        w.obj.prio  = prio;
        w.obj.mode  = mode;
        return w;
    endfunction

    function automatic layer_word_u random_word(input logic is_obj);
        layer_word_u w;
        w          = 20'($urandom);
        w.bg.index = ($urandom_range(3) == 0) ? 8'd0 : 8'($urandom);  // some transparent
        if (is_obj) begin
            w.obj.mode = 2'($urandom_range(2));
        end
        return w;
    endfunction

    function automatic bg_set_t random_bgs();
        bg_set_t b;
        for (int k = 0; k < NUM_BG; k++) begin
            b[k] = random_word(1'b0);
        end
        return b;
    endfunction

    initial begin
        bg_set_t b;
        int      r0;
        void'($urandom(8281));
        arst_n      = 1'b0;
        pixel_valid = 1'b0;
        col         = '0;
        line        = '0;
        obj_word    = '0;
        bg_words    = '0;
        disp_ctrl   = 16'h1f00;
        win_in      = '0;
        win_out     = '0;
        win0_h      = '0;
        win1_h      = '0;
        win0_v      = '0;
        win1_v      = '0;
        pram_data   = '0;
        for (int a = 0; a < (1 << PRAM_AW); a++) begin
            pram[a] = {1'b1, entry_color({a[6:0], 1'b1}), 1'b1, entry_color({a[6:0], 1'b0})};
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < 40; i++) begin
            disp_ctrl = {3'b000, 5'($urandom), 8'h00};  // windows off
            send_pixel(8'($urandom), 8'($urandom), random_word(1'b1), random_bgs());
        end
        wait_drain();
        report_test("random without windows");

        disp_ctrl = 16'h1f00;
        b         = '0;
        b[0]      = make_word(8'h20, 2'd1, OBJ_MODE_NORMAL);
        send_pixel(8'd0, 8'd0, make_word(8'h10, 2'd1, OBJ_MODE_NORMAL), b);
        b    = '0;
        b[1] = make_word(8'h31, 2'd2, OBJ_MODE_NORMAL);
        b[3] = make_word(8'h35, 2'd2, OBJ_MODE_NORMAL);
        send_pixel(8'd1, 8'd0, '0, b);  // bg1 ahead of bg3
        send_pixel(8'd2, 8'd0, '0, '0);
        wait_drain();
        report_test("priority ties");

        disp_ctrl = 16'hff00;
        win0_h    = {8'd10, 8'd50};
        win0_v    = {8'd10, 8'd50};
        win1_h    = {8'd40, 8'd90};
        win1_v    = {8'd40, 8'd90};
        win_in    = {8'h14, 8'h23};  // win0 shows bg0 bg1 with effects
        win_out   = {8'h25, 8'h08};
        for (int k = 0; k < NUM_BG; k++) begin
            b[k] = make_word(8'h11 + 8'(k * 33), 2'(3 - k), OBJ_MODE_NORMAL);
        end
        send_pixel(8'd20, 8'd20, make_word(8'h90, 2'd1, OBJ_MODE_NORMAL), b);
        send_pixel(8'd45, 8'd45, make_word(8'h90, 2'd1, OBJ_MODE_NORMAL), b);  // overlap
        send_pixel(8'd70, 8'd70, make_word(8'h90, 2'd1, OBJ_MODE_NORMAL), b);
        send_pixel(8'd120, 8'd120, make_word(8'h90, 2'd1, OBJ_MODE_WINDOW), b);
        send_pixel(8'd120, 8'd120, make_word(8'h90, 2'd1, OBJ_MODE_NORMAL), b);
        wait_drain();
        report_test("window select");

        disp_ctrl = 16'h1f00;
        for (int i = 0; i < 8; i++) begin
            send_pixel(8'($urandom), 8'($urandom),
                       make_word(8'($urandom) | 8'h01, 2'd0, OBJ_MODE_WINDOW), random_bgs());
        end
        wait_drain();
        report_test("obj window word hidden");

        b    = '0;
        b[0] = make_word(8'h21, 2'd1, OBJ_MODE_NORMAL);
        r0   = reads;
        send_pixel(8'd3, 8'd3, make_word(8'h20, 2'd0, OBJ_MODE_NORMAL), b);
        wait_drain();
        check_count("pram reads shared word", reads - r0, 1);
        r0 = reads;
        send_pixel(8'd4, 8'd3, make_word(8'h01, 2'd0, OBJ_MODE_NORMAL), '0);  // backdrop word
        wait_drain();
        check_count("pram reads shared backdrop", reads - r0, 1);
        report_test("shared palette word");

        for (int i = 0; i < 30; i++) begin
            disp_ctrl = 16'($urandom) | 16'h1f00;
            win_in    = 16'($urandom);
            win_out   = 16'($urandom);
            send_pixel(8'($urandom_range(127)), 8'($urandom_range(127)), random_word(1'b1),
                       random_bgs());
        end
        wait_drain();
        check_count("pram reads total", reads, pred_reads);
        report_test("back to back");

        $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pixel_priority.f
+incdir+verification
source/pixel_priority_pkg.sv
source/window_mask.sv
source/rank_stage.sv
source/palette_fetch.sv
source/pixel_priority_top.sv
verification/pixel_priority_tb.sv
